// File: design/isa_pkg.sv
// RISC-V instruction formats
package isa_pkg;

    // Major opcodes seen at dispatch
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,  // No destination
        BRANCH = 7'b1100011,  // No destination
        LUI    = 7'b0110111,  // No sources
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef logic [4:0] arch_reg_t;  // x0 to x31

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    // Immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        arch_reg_t   rs1;
        logic [2:0]  funct3;
        arch_reg_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    // One fetched word seen through either layout
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

endpackage

// File: design/rename_pkg.sv
// Renaming widths and types
package rename_pkg;

    localparam int WIDTH     = 2;   // Dispatch and retire width
    localparam int ARCH_REGS = 32;

    typedef logic [5:0] phys_reg_t;  // Physical tag
    typedef logic [3:0] rob_idx_t;   // ROB slot number
    typedef logic [1:0] count_t;     // 0 to WIDTH slots

    // Register fields and use flags of one instruction
    typedef struct packed {
        isa_pkg::arch_reg_t rs1;
        isa_pkg::arch_reg_t rs2;
        isa_pkg::arch_reg_t rd;
        logic               uses_rs1;
        logic               uses_rs2;
        logic               writes_rd;  // Never set for x0
    } decoded_t;

    // One in-flight instruction
    typedef struct packed {
        isa_pkg::arch_reg_t rd;
        phys_reg_t          new_prd;    // Tag given at dispatch
        phys_reg_t          old_prd;    // Freed on retire
        logic               writes_rd;
        logic               done;       // Set by completion
    } rob_entry_t;

endpackage

// File: design/rename_ifs.sv
// Rename interconnect interfaces
`timescale 1ns/1ns

// Free tags offered to dispatch
interface alloc_if;
    import rename_pkg::*;

    count_t                avail;  // Free tags clamped to WIDTH
    phys_reg_t [WIDTH-1:0] pick;   // Lowest free first
    count_t                take;   // Tags consumed at the edge

    modport producer (
        output avail,
        output pick,
        input  take
    );
    modport consumer (
        input  avail,
        input  pick,
        output take
    );
endinterface

// Oldest ROB entries ready to retire
interface retire_if;
    import rename_pkg::*;

    count_t                 count;  // Entries retiring this cycle
    rob_entry_t [WIDTH-1:0] head;   // Oldest first

    modport producer (
        output count,
        output head
    );
    modport consumer (
        input count,
        input head
    );
endinterface

// File: design/inst_decode.sv
// Register field decoder
`timescale 1ns/1ns

module inst_decode (
    input  isa_pkg::instr_word_u inst,
    output rename_pkg::decoded_t dec
);
    import isa_pkg::*;

    always_comb begin
        dec.rs1      = inst.i_fmt.rs1;  // Same bits in every format used here
        dec.rs2      = inst.r_fmt.rs2;
        dec.rd       = inst.i_fmt.rd;
        dec.uses_rs1 = 1'b0;
        dec.uses_rs2 = 1'b0;
        dec.writes_rd = 1'b0;
        case (inst.r_fmt.opcode)
            OP: begin
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OP_IMM, LOAD, JALR: begin
                dec.uses_rs1  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            STORE, BRANCH: begin  // Two sources and no result
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
            end
            LUI, JAL: begin
                dec.writes_rd = 1'b1;
            end
            default: begin
                dec.writes_rd = 1'b0;  // Unknown opcode renames nothing
            end
        endcase
        // x0 keeps tag 0 forever
        if (inst.i_fmt.rd == '0) begin
            dec.writes_rd = 1'b0;
        end
    end

endmodule

// File: design/rename_map.sv
// Map table and dispatch acceptance
`timescale 1ns/1ns

module rename_map #(
    parameter int PHYS_REGS = 40
) (
    input  logic                                          clock,
    input  logic                                          rst_n,
    input  rename_pkg::count_t                            in_count,  // Slots offered
    input  rename_pkg::decoded_t  [rename_pkg::WIDTH-1:0] dec,
    input  rename_pkg::count_t                            rob_free,
    alloc_if.consumer                                     alloc,
    output rename_pkg::count_t                            accept_count,
    output rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] phys_rs1,
    output rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] phys_rs2,
    output rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] phys_rd,
    output rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] old_prd
);
    import rename_pkg::*;

    localparam int TAG_W = $clog2(PHYS_REGS);  // Entry width follows the tag space
    typedef logic [TAG_W-1:0] map_tag_t;

    map_tag_t              map_q [ARCH_REGS];  // Arch to phys
    logic      [WIDTH-1:0] wr;                 // Slot writes rd
    logic                  ok0, ok1;           // Slot accepted
    count_t                need1;              // Tags needed for both slots
    phys_reg_t [WIDTH-1:0] new_tag;
    logic                  byp_rs1, byp_rs2, byp_rd;

    ////////////////////
    // Acceptance and tag choice
    always_comb begin
        wr[0] = dec[0].writes_rd;
        wr[1] = dec[1].writes_rd;
        need1 = count_t'(wr[0]) + count_t'(wr[1]);
        ok0   = (in_count != '0) && (rob_free != '0) && (!wr[0] || alloc.avail != '0);
        ok1   = ok0 && (in_count == 2'd2) && (rob_free == 2'd2) && (alloc.avail >= need1);
        accept_count = ok1 ? 2'd2 : (ok0 ? 2'd1 : 2'd0);
        alloc.take   = count_t'(ok0 && wr[0]) + count_t'(ok1 && wr[1]);
        new_tag[0] = alloc.pick[0];
        new_tag[1] = wr[0] ? alloc.pick[1] : alloc.pick[0];  // Pick 0 to first writer
        phys_rd[0] = wr[0] ? new_tag[0] : '0;
        phys_rd[1] = wr[1] ? new_tag[1] : '0;
    end

    ////////////////////
    // Source lookup with slot 1 bypass
    always_comb begin
        byp_rs1 = wr[0] && (dec[1].rs1 == dec[0].rd);
        byp_rs2 = wr[0] && (dec[1].rs2 == dec[0].rd);
        byp_rd  = wr[0] && (dec[1].rd == dec[0].rd);   // Same rd twice in a group
        phys_rs1[0] = dec[0].uses_rs1 ? phys_reg_t'(map_q[dec[0].rs1]) : '0;
        phys_rs2[0] = dec[0].uses_rs2 ? phys_reg_t'(map_q[dec[0].rs2]) : '0;
        phys_rs1[1] = !dec[1].uses_rs1 ? '0 :
                      (byp_rs1 ? new_tag[0] : phys_reg_t'(map_q[dec[1].rs1]));
        phys_rs2[1] = !dec[1].uses_rs2 ? '0 :
                      (byp_rs2 ? new_tag[0] : phys_reg_t'(map_q[dec[1].rs2]));
        old_prd[0]  = phys_reg_t'(map_q[dec[0].rd]);
        old_prd[1]  = byp_rd ? new_tag[0] : phys_reg_t'(map_q[dec[1].rd]);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= map_tag_t'(i);  // Identity mapping
            end
        end else begin
            if (ok0 && wr[0]) begin
                map_q[dec[0].rd] <= map_tag_t'(new_tag[0]);
            end
            if (ok1 && wr[1]) begin
                map_q[dec[1].rd] <= map_tag_t'(new_tag[1]);  // Younger slot wins
            end
        end
    end

endmodule

// File: design/free_list.sv
// Physical register free list
`timescale 1ns/1ns

module free_list #(
    parameter int PHYS_REGS = 40
) (
    input  logic       clock,
    input  logic       rst_n,
    alloc_if.producer  alloc,
    retire_if.consumer ret
);
    import rename_pkg::*;

    logic [PHYS_REGS-1:0] free_q;  // One bit per tag, set when free
    logic [PHYS_REGS-1:0] free_d;

    ////////////////////
    // Lowest-first two-pick search
    always_comb begin : pick_search
        int found;
        found = 0;
        alloc.pick = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (free_q[i] && found < WIDTH) begin
                alloc.pick[found] = phys_reg_t'(i);
                found++;
            end
        end
        alloc.avail = count_t'(found);  // Already clamped by the search
    end

    ////////////////////
    // Take and release
    always_comb begin
        free_d = free_q;
        for (int k = 0; k < WIDTH; k++) begin
            if (count_t'(k) < alloc.take) begin
                free_d[alloc.pick[k]] = 1'b0;
            end
        end
        // Old mapping of each retiring writer comes back
        for (int k = 0; k < WIDTH; k++) begin
            if (count_t'(k) < ret.count && ret.head[k].writes_rd) begin
                free_d[ret.head[k].old_prd] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            free_q <= {PHYS_REGS{1'b1}} << ARCH_REGS;  // Tags above the arch set
        end else begin
            free_q <= free_d;
        end
    end

endmodule

// File: design/rob.sv
// Reorder buffer
`timescale 1ns/1ns

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                                          clock,
    input  logic                                          rst_n,
    input  rename_pkg::count_t                            accept_count,
    input  rename_pkg::decoded_t  [rename_pkg::WIDTH-1:0] dec,
    input  rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] phys_rd,
    input  rename_pkg::phys_reg_t [rename_pkg::WIDTH-1:0] old_prd,
    input  logic                  [rename_pkg::WIDTH-1:0] cmp_valid,
    input  rename_pkg::rob_idx_t  [rename_pkg::WIDTH-1:0] cmp_rob_idx,
    output rename_pkg::count_t                            rob_free,   // Clamped to WIDTH
    output rename_pkg::rob_idx_t  [rename_pkg::WIDTH-1:0] alloc_idx,
    retire_if.producer                                    ret
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   occ_t;  // Holds 0 to ROB_DEPTH

    rob_entry_t [ROB_DEPTH-1:0] entries;  // Live from head for occupancy entries
    ptr_t                       head, tail;
    occ_t                       occupancy;
    occ_t                       spare;
    ptr_t       [WIDTH-1:0]     wr_ptr, rd_ptr;
    logic       [WIDTH-1:0]     ready;     // Retire in order

    always_comb begin
        spare    = occ_t'(ROB_DEPTH) - occupancy;
        rob_free = (spare >= occ_t'(2)) ? 2'd2 : count_t'(spare);
        for (int k = 0; k < WIDTH; k++) begin
            wr_ptr[k]    = tail + ptr_t'(k);  // Wraps at ROB_DEPTH
            rd_ptr[k]    = head + ptr_t'(k);
            alloc_idx[k] = rob_idx_t'(wr_ptr[k]);
            ret.head[k]  = entries[rd_ptr[k]];
        end
        ready[0]  = (occupancy > occ_t'(0)) && entries[rd_ptr[0]].done;
        ready[1]  = ready[0] && (occupancy > occ_t'(1)) && entries[rd_ptr[1]].done;
        ret.count = count_t'(ready[0]) + count_t'(ready[1]);
    end

    ////////////////////
    // Entry writes and completion marks
    always_ff @(posedge clock) begin
        for (int k = 0; k < WIDTH; k++) begin
            if (count_t'(k) < accept_count) begin
                entries[wr_ptr[k]].rd        <= dec[k].rd;
                entries[wr_ptr[k]].new_prd   <= phys_rd[k];
                entries[wr_ptr[k]].old_prd   <= old_prd[k];
                entries[wr_ptr[k]].writes_rd <= dec[k].writes_rd;
                entries[wr_ptr[k]].done      <= 1'b0;
            end
        end
        for (int k = 0; k < WIDTH; k++) begin
            if (cmp_valid[k]) begin
                entries[ptr_t'(cmp_rob_idx[k])].done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head + ptr_t'(ret.count);
            tail      <= tail + ptr_t'(accept_count);
            occupancy <= occupancy + occ_t'(accept_count) - occ_t'(ret.count);
        end
    end

endmodule

// File: design/rename_core.sv
// Rename and commit core
`timescale 1ns/1ns

module rename_core #(
    parameter int PHYS_REGS = 40,
    parameter int ROB_DEPTH = 16
) (
    input  logic                                           clock,
    input  logic                                           rst_n,
    input  rename_pkg::count_t                             in_count,
    input  isa_pkg::instr_word_u   [rename_pkg::WIDTH-1:0] inst,        // Oldest in slot 0
    output rename_pkg::count_t                             accept_count,
    output rename_pkg::phys_reg_t  [rename_pkg::WIDTH-1:0] phys_rs1,
    output rename_pkg::phys_reg_t  [rename_pkg::WIDTH-1:0] phys_rs2,
    output rename_pkg::phys_reg_t  [rename_pkg::WIDTH-1:0] phys_rd,
    output rename_pkg::rob_idx_t   [rename_pkg::WIDTH-1:0] rob_idx,
    input  logic                   [rename_pkg::WIDTH-1:0] cmp_valid,
    input  rename_pkg::rob_idx_t   [rename_pkg::WIDTH-1:0] cmp_rob_idx,
    output rename_pkg::count_t                             retire_count,
    output isa_pkg::arch_reg_t     [rename_pkg::WIDTH-1:0] retire_rd,
    output rename_pkg::phys_reg_t  [rename_pkg::WIDTH-1:0] retire_prd   // New tag of retiree
);
    import rename_pkg::*;

    decoded_t  [WIDTH-1:0] dec;
    phys_reg_t [WIDTH-1:0] old_prd;   // Previous mapping per slot
    count_t                rob_free;

    alloc_if  alloc ();  // Free list to map
    retire_if ret ();    // ROB to free list

    ////////////////////
    // Decode
    for (genvar k = 0; k < WIDTH; k++) begin : g_dec
        inst_decode u_dec (
            .inst (inst[k]),
            .dec  (dec[k])
        );
    end

    ////////////////////
    // Rename
    rename_map #(.PHYS_REGS(PHYS_REGS)) u_map (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_count     (in_count),
        .dec          (dec),
        .rob_free     (rob_free),
        .alloc        (alloc.consumer),
        .accept_count (accept_count),
        .phys_rs1     (phys_rs1),
        .phys_rs2     (phys_rs2),
        .phys_rd      (phys_rd),
        .old_prd      (old_prd)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) u_free (
        .clock (clock),
        .rst_n (rst_n),
        .alloc (alloc.producer),
        .ret   (ret.consumer)
    );

    ////////////////////
    // Commit
    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clock        (clock),
        .rst_n        (rst_n),
        .accept_count (accept_count),
        .dec          (dec),
        .phys_rd      (phys_rd),
        .old_prd      (old_prd),
        .cmp_valid    (cmp_valid),
        .cmp_rob_idx  (cmp_rob_idx),
        .rob_free     (rob_free),
        .alloc_idx    (rob_idx),
        .ret          (ret.producer)
    );

    assign retire_count = ret.count;
    for (genvar k = 0; k < WIDTH; k++) begin : g_ret
        assign retire_rd[k]  = ret.head[k].rd;
        assign retire_prd[k] = ret.head[k].new_prd;
    end

endmodule

// File: dv/rename_assert.sv
// ROB occupancy and retire checks
`timescale 1ns/1ns

module rename_assert #(
    parameter int ROB_DEPTH = 16
) (
    input logic                         clock,
    input logic                         rst_n,
    input rename_pkg::count_t           accept_count,
    input rename_pkg::count_t           rob_free,
    input rename_pkg::count_t           retire_count,
    input logic [$clog2(ROB_DEPTH):0]   occupancy
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(ROB_DEPTH);
    typedef logic [PTR_W:0]   occ_t;

    a_occupancy_bound: assert property (@(posedge clock) disable iff (!rst_n)
        occupancy <= occ_t'(ROB_DEPTH))
        else $error("ROB holds more entries than its depth");

    a_retire_bound: assert property (@(posedge clock) disable iff (!rst_n)
        occ_t'(retire_count) <= occupancy)
        else $error("ROB retires more entries than it holds");

    // Dispatch seen from the ROB side
    a_accept_bound: assert property (@(posedge clock) disable iff (!rst_n)
        accept_count <= rob_free)
        else $error("Dispatch accepted more entries than free ROB slots");

endmodule

bind rob rename_assert #(.ROB_DEPTH(ROB_DEPTH)) u_assert (
    .clock        (clock),
    .rst_n        (rst_n),
    .accept_count (accept_count),
    .rob_free     (rob_free),
    .retire_count (ret.count),
    .occupancy    (occupancy)
);

// File: dv/rename_tb.sv
// Rename core testbench
`timescale 1ns/1ns

module rename_tb;
    import isa_pkg::*;
    import rename_pkg::*;

    localparam int HALF_PERIOD = 20;   // 40 ns clock
    localparam int NUM_FIELDS  = 20;   // Columns per vector line
    localparam int MAX_VECS    = 64;
    localparam int END_MARK    = 'hf;  // First column of the closing line

    logic                    clock;
    logic                    rst_n;
    count_t                  in_count;
    instr_word_u [WIDTH-1:0] inst;
    count_t                  accept_count;
    phys_reg_t   [WIDTH-1:0] phys_rs1, phys_rs2, phys_rd;
    rob_idx_t    [WIDTH-1:0] rob_idx;
    logic        [WIDTH-1:0] cmp_valid;
    rob_idx_t    [WIDTH-1:0] cmp_rob_idx;
    count_t                  retire_count;
    arch_reg_t   [WIDTH-1:0] retire_rd;
    phys_reg_t   [WIDTH-1:0] retire_prd;

    logic [31:0] vec_mem [MAX_VECS*NUM_FIELDS];  // Flat, one line per NUM_FIELDS words
    int          num_vecs;
    logic        loaded;

    rename_core #(.PHYS_REGS(40), .ROB_DEPTH(16)) u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .in_count     (in_count),
        .inst         (inst),
        .accept_count (accept_count),
        .phys_rs1     (phys_rs1),
        .phys_rs2     (phys_rs2),
        .phys_rd      (phys_rd),
        .rob_idx      (rob_idx),
        .cmp_valid    (cmp_valid),
        .cmp_rob_idx  (cmp_rob_idx),
        .retire_count (retire_count),
        .retire_rd    (retire_rd),
        .retire_prd   (retire_prd)
    );

    always #HALF_PERIOD clock = ~clock;

    ////////////////////
    // Result checks
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_tag(input string name, input phys_reg_t exp, input phys_reg_t act);
        if (act !== exp) abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_idx(input string name, input rob_idx_t exp, input rob_idx_t act);
        if (act !== exp) abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_arch(input string name, input arch_reg_t exp, input arch_reg_t act);
        if (act !== exp) abort_run($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
    endtask

    function automatic logic [31:0] vec_field(input int v, input int f);
        return vec_mem[v*NUM_FIELDS + f];
    endfunction

    ////////////////////
    // Vector handling
    task automatic apply_vector(input int v);
        in_count       = count_t'(vec_field(v, 0));
        inst[0]        = instr_word_u'(vec_field(v, 1));
        inst[1]        = instr_word_u'(vec_field(v, 2));
        cmp_valid      = WIDTH'(vec_field(v, 3));
        cmp_rob_idx[0] = rob_idx_t'(vec_field(v, 4));
        cmp_rob_idx[1] = rob_idx_t'(vec_field(v, 5));
    endtask

    task automatic check_vector(input int v);
        count_t exp_acc;
        count_t exp_ret;
        exp_acc = count_t'(vec_field(v, 6));
        exp_ret = count_t'(vec_field(v, 15));
        check_count($sformatf("vec %0d accept_count", v), exp_acc, accept_count);
        for (int k = 0; k < WIDTH; k++) begin
            if (k < int'(exp_acc)) begin  // Only accepted slots carry tags
                check_tag($sformatf("vec %0d phys_rs1[%0d]", v, k),
                          phys_reg_t'(vec_field(v, 7 + 4*k)), phys_rs1[k]);
                check_tag($sformatf("vec %0d phys_rs2[%0d]", v, k),
                          phys_reg_t'(vec_field(v, 8 + 4*k)), phys_rs2[k]);
                check_tag($sformatf("vec %0d phys_rd[%0d]", v, k),
                          phys_reg_t'(vec_field(v, 9 + 4*k)), phys_rd[k]);
                check_idx($sformatf("vec %0d rob_idx[%0d]", v, k),
                          rob_idx_t'(vec_field(v, 10 + 4*k)), rob_idx[k]);
            end
        end
        check_count($sformatf("vec %0d retire_count", v), exp_ret, retire_count);
        for (int k = 0; k < WIDTH; k++) begin
            if (k < int'(exp_ret)) begin
                check_arch($sformatf("vec %0d retire_rd[%0d]", v, k),
                           arch_reg_t'(vec_field(v, 16 + 2*k)), retire_rd[k]);
                check_tag($sformatf("vec %0d retire_prd[%0d]", v, k),
                          phys_reg_t'(vec_field(v, 17 + 2*k)), retire_prd[k]);
            end
        end
    endtask

    initial begin : main_seq
        clock       = 1'b0;
        rst_n       = 1'b0;
        in_count    = '0;
        inst        = '0;
        cmp_valid   = '0;
        cmp_rob_idx = '0;
        loaded      = 1'b0;
        $readmemh("dv/rename_vectors.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && vec_field(num_vecs, 0) != END_MARK) begin
            num_vecs++;
        end
        if (num_vecs == MAX_VECS) abort_run("Vector file has no end marker line");
        loaded = 1'b1;
        repeat (5) @(posedge clock);  // Reset held for 5 cycles
        @(negedge clock);
        rst_n = 1'b1;
        for (int v = 0; v < num_vecs; v++) begin
            @(negedge clock);
            apply_vector(v);
            #(HALF_PERIOD - 5);        // Just before the rising edge
            check_vector(v);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // Ends a stuck run
    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (num_vecs + 5) * 2 * HALF_PERIOD + 400;
        #(limit_ns);
        abort_run("Watchdog timeout, the vector run did not finish in time");
    end

endmodule

// File: dv/rename_vectors.txt
// in_count inst0 inst1 cmp_valid cmp_idx0 cmp_idx1 | accept rs1_0 rs2_0 rd_0 idx_0 rs1_1 rs2_1 rd_1 idx_1
// | retire_count retire_rd0 retire_prd0 retire_rd1 retire_prd1   (all hex, last line f ends the run)
0 00000000 00000000 0 0 0  0 00 00 00 0 00 00 00 0  0 00 00 00 00
2 003102b3 00028333 0 0 0  2 02 03 20 0 20 00 21 1  0 00 00 00 00
1 006283b3 00000000 0 0 0  1 20 21 22 2 00 00 00 0  0 00 00 00 00
2 00208433 008404b3 0 0 0  2 01 02 23 3 23 23 24 4  0 00 00 00 00
2 00000533 00550593 0 0 0  2 00 00 25 5 25 00 26 6  0 00 00 00 00
2 00108633 001086b3 0 0 0  1 01 01 27 7 00 00 00 0  0 00 00 00 00
2 00208733 00112023 0 0 0  0 00 00 00 0 00 00 00 0  0 00 00 00 00
2 0053a023 00208733 0 0 0  1 22 20 00 8 00 00 00 0  0 00 00 00 00
2 00112023 00112023 0 0 0  2 02 01 00 9 02 01 00 a  0 00 00 00 00
2 00112023 00112023 0 0 0  2 02 01 00 b 02 01 00 c  0 00 00 00 00
2 00112023 00112023 0 0 0  2 02 01 00 d 02 01 00 e  0 00 00 00 00
2 00112023 00112023 0 0 0  1 02 01 00 f 00 00 00 0  0 00 00 00 00
1 00112023 00000000 1 1 0  0 00 00 00 0 00 00 00 0  0 00 00 00 00
0 00000000 00000000 1 0 0  0 00 00 00 0 00 00 00 0  0 00 00 00 00
0 00000000 00000000 0 0 0  0 00 00 00 0 00 00 00 0  2 05 20 06 21
2 00208a33 001a0ab3 3 2 3  2 01 02 05 0 05 01 06 1  0 00 00 00 00
0 00000000 00000000 0 0 0  0 00 00 00 0 00 00 00 0  2 07 22 08 23
1 000a0b33 00000000 0 0 0  1 05 00 07 2 00 00 00 0  0 00 00 00 00
f

// File: verilog.f
design/isa_pkg.sv
design/rename_pkg.sv
design/rename_ifs.sv
design/inst_decode.sv
design/rename_map.sv
design/free_list.sv
design/rob.sv
design/rename_core.sv
dv/rename_assert.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the rename core simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_tb \
    -f verilog.f \
    -o rename_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/rename_sim
